/* rtl/mips_decode_pkg.sv */
package mips_decode_pkg;

    //************************************************************
    // widths and fixed registers
    //************************************************************
    localparam int DATA_W     = 32;  // data and pc width
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;   // 32 general registers

    localparam logic [REG_ADDR_W-1:0] REG_ZERO = 5'd0;   // hardwired zero, never a hazard
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // return address register

    localparam logic [DATA_W-1:0] DELAY_SLOT_OFFSET = 32'd4;  // pc of the delay slot
    localparam logic [DATA_W-1:0] LINK_OFFSET       = 32'd8;  // return skips the delay slot

    //************************************************************
    // instruction encodings
    //************************************************************
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,  // decoded further by funct
        OP_REGIMM  = 6'b000001,  // decoded further by rt
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

/* rtl/decode_bus_if.sv */
`timescale 1ns/1ns

interface decode_bus_if;

    mips_decode_pkg::alu_op_e                     alu_op;
    logic [mips_decode_pkg::DATA_W-1:0]     operand1;   // rs side
    logic [mips_decode_pkg::DATA_W-1:0]     operand2;   // rt or immediate side
    logic                                   rf_wen;
    logic [mips_decode_pkg::REG_ADDR_W-1:0] rf_wdest;   // REG_ZERO when nothing is written

    modport dec (
        output alu_op, operand1, operand2, rf_wen, rf_wdest
    );

    modport exe_reg (
        input  alu_op, operand1, operand2, rf_wen, rf_wdest
    );

endinterface

/* rtl/id_inst_reg.sv */
`timescale 1ns/1ns

module id_inst_reg (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fetch_valid,
    input  logic [mips_decode_pkg::DATA_W-1:0] fetch_pc,
    input  logic [mips_decode_pkg::INST_W-1:0] fetch_inst,
    input  logic                               stall,
    input  logic                               can_accept,
    output logic                               fetch_ready,
    output logic                               held_valid,
    output logic [mips_decode_pkg::DATA_W-1:0] held_pc,
    output logic [mips_decode_pkg::INST_W-1:0] held_inst,
    output logic                               issue
);

    // leaves decode only when hazards are clear and execute has room
    assign issue       = held_valid & ~stall & can_accept;
    assign fetch_ready = ~held_valid | issue;   // empty, or emptying this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (fetch_ready) begin
            held_valid <= fetch_valid;          // reload or drain
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid & fetch_ready) begin
            held_pc   <= fetch_pc;
            held_inst <= fetch_inst;
        end
    end

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
    input  logic                                   held_valid,
    input  logic [mips_decode_pkg::DATA_W-1:0]     held_pc,
    input  logic [mips_decode_pkg::INST_W-1:0]     held_inst,
    input  logic [mips_decode_pkg::DATA_W-1:0]     rs_value,
    input  logic [mips_decode_pkg::DATA_W-1:0]     rt_value,
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_wdest,
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] mem_wdest,
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] wb_wdest,
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic                                   stall,
    decode_bus_if.dec                              dec
);

    //************************************************************
    // field split
    //************************************************************
    logic [5:0]  op;
    logic [4:0]  rs, rt, rd, sa;
    logic [5:0]  funct;
    logic [15:0] imm;

    assign op    = held_inst[31:26];
    assign rs    = held_inst[25:21];
    assign rt    = held_inst[20:16];
    assign rd    = held_inst[15:11];
    assign sa    = held_inst[10:6];
    assign funct = held_inst[5:0];
    assign imm   = held_inst[15:0];

    assign rs_addr = rs;                        // straight to the register file
    assign rt_addr = rt;

    //************************************************************
    // instruction classes
    //************************************************************
    logic op_special, op_regimm, sa_zero, rs_zero, rt_zero;
    logic is_alu_r, is_shf_sa, is_shf_v, is_jr, is_jalr, is_jal;
    logic is_imm_zero, is_imm_sign, is_br_rr, is_br_z, is_br_link;
    logic link, use_rs, use_rt, wdest_rt, wdest_31, wdest_rd;

    assign op_special = (op == mips_decode_pkg::OP_SPECIAL);
    assign op_regimm  = (op == mips_decode_pkg::OP_REGIMM);
    assign sa_zero    = (sa == 5'd0);
    assign rs_zero    = (rs == mips_decode_pkg::REG_ZERO);
    assign rt_zero    = (rt == mips_decode_pkg::REG_ZERO);

    assign is_alu_r  = op_special & sa_zero & (funct inside {
                           mips_decode_pkg::FN_ADDU, mips_decode_pkg::FN_SUBU,
                           mips_decode_pkg::FN_SLT,  mips_decode_pkg::FN_SLTU,
                           mips_decode_pkg::FN_AND,  mips_decode_pkg::FN_NOR,
                           mips_decode_pkg::FN_OR,   mips_decode_pkg::FN_XOR});
    assign is_shf_sa = op_special & rs_zero & (funct inside {
                           mips_decode_pkg::FN_SLL, mips_decode_pkg::FN_SRL,
                           mips_decode_pkg::FN_SRA});
    assign is_shf_v  = op_special & sa_zero & (funct inside {
                           mips_decode_pkg::FN_SLLV, mips_decode_pkg::FN_SRLV,
                           mips_decode_pkg::FN_SRAV});
    assign is_jr     = op_special & rt_zero & (rd == mips_decode_pkg::REG_ZERO) & sa_zero
                     & (funct == mips_decode_pkg::FN_JR);
    assign is_jalr   = op_special & rt_zero & (rd == mips_decode_pkg::LINK_REG) & sa_zero
                     & (funct == mips_decode_pkg::FN_JALR);
    assign is_jal    = (op == mips_decode_pkg::OP_JAL);

    assign is_imm_zero = (op inside {mips_decode_pkg::OP_ANDI, mips_decode_pkg::OP_ORI,
                                     mips_decode_pkg::OP_XORI})
                       | ((op == mips_decode_pkg::OP_LUI) & rs_zero);
    assign is_imm_sign = op inside {mips_decode_pkg::OP_ADDIU, mips_decode_pkg::OP_SLTI,
                                    mips_decode_pkg::OP_SLTIU};
    assign is_br_rr    = op inside {mips_decode_pkg::OP_BEQ, mips_decode_pkg::OP_BNE};
    assign is_br_z     = ((op inside {mips_decode_pkg::OP_BLEZ, mips_decode_pkg::OP_BGTZ})
                          & rt_zero)
                       | (op_regimm & (rt inside {mips_decode_pkg::RI_BLTZ,
                                                  mips_decode_pkg::RI_BGEZ}));
    assign is_br_link  = op_regimm & (rt inside {mips_decode_pkg::RI_BLTZAL,
                                                 mips_decode_pkg::RI_BGEZAL});

    assign link   = is_jal | is_jalr | is_br_link;  // writes pc+8
    assign use_rs = is_alu_r | is_shf_v | is_jr | is_jalr | is_imm_zero | is_imm_sign
                  | is_br_rr | is_br_z | is_br_link;
    assign use_rt = is_alu_r | is_shf_sa | is_shf_v | is_br_rr;

    assign wdest_rt = is_imm_zero | is_imm_sign;
    assign wdest_31 = is_jal | is_br_link;
    assign wdest_rd = is_alu_r | is_shf_sa | is_shf_v | is_jalr;

    //************************************************************
    // alu operation, operands and destination
    //************************************************************
    mips_decode_pkg::alu_op_e alu_op;

    always_comb begin
        alu_op = mips_decode_pkg::ALU_ADD;      // addu, addiu and links
        case (op)
            mips_decode_pkg::OP_SPECIAL: begin
                case (funct)
                    mips_decode_pkg::FN_SUBU: alu_op = mips_decode_pkg::ALU_SUB;
                    mips_decode_pkg::FN_SLT:  alu_op = mips_decode_pkg::ALU_SLT;
                    mips_decode_pkg::FN_SLTU: alu_op = mips_decode_pkg::ALU_SLTU;
                    mips_decode_pkg::FN_AND:  alu_op = mips_decode_pkg::ALU_AND;
                    mips_decode_pkg::FN_NOR:  alu_op = mips_decode_pkg::ALU_NOR;
                    mips_decode_pkg::FN_OR:   alu_op = mips_decode_pkg::ALU_OR;
                    mips_decode_pkg::FN_XOR:  alu_op = mips_decode_pkg::ALU_XOR;
                    mips_decode_pkg::FN_SLL,
                    mips_decode_pkg::FN_SLLV: alu_op = mips_decode_pkg::ALU_SLL;
                    mips_decode_pkg::FN_SRL,
                    mips_decode_pkg::FN_SRLV: alu_op = mips_decode_pkg::ALU_SRL;
                    mips_decode_pkg::FN_SRA,
                    mips_decode_pkg::FN_SRAV: alu_op = mips_decode_pkg::ALU_SRA;
                    default: ;
                endcase
            end
            mips_decode_pkg::OP_SLTI:  alu_op = mips_decode_pkg::ALU_SLT;
            mips_decode_pkg::OP_SLTIU: alu_op = mips_decode_pkg::ALU_SLTU;
            mips_decode_pkg::OP_ANDI:  alu_op = mips_decode_pkg::ALU_AND;
            mips_decode_pkg::OP_ORI:   alu_op = mips_decode_pkg::ALU_OR;
            mips_decode_pkg::OP_XORI:  alu_op = mips_decode_pkg::ALU_XOR;
            mips_decode_pkg::OP_LUI:   alu_op = mips_decode_pkg::ALU_LUI;
            default: ;
        endcase
    end

    assign dec.alu_op   = alu_op;
    assign dec.operand1 = link      ? held_pc :
                          is_shf_sa ? {{(mips_decode_pkg::DATA_W-5){1'b0}}, sa} : rs_value;
    assign dec.operand2 = link        ? mips_decode_pkg::LINK_OFFSET :
                          is_imm_zero ? {{(mips_decode_pkg::DATA_W-16){1'b0}}, imm} :
                          is_imm_sign ? {{(mips_decode_pkg::DATA_W-16){imm[15]}}, imm} :
                                        rt_value;
    assign dec.rf_wen   = wdest_rt | wdest_31 | wdest_rd;
    assign dec.rf_wdest = wdest_rt ? rt :
                          wdest_31 ? mips_decode_pkg::LINK_REG :
                          wdest_rd ? rd : mips_decode_pkg::REG_ZERO;

    //************************************************************
    // hazard stall against pending writes
    //************************************************************
    logic rs_hit, rt_hit;

    assign rs_hit = use_rs & ~rs_zero & ((rs == exe_wdest) | (rs == mem_wdest) | (rs == wb_wdest));
    assign rt_hit = use_rt & ~rt_zero & ((rt == exe_wdest) | (rt == mem_wdest) | (rt == wb_wdest));
    assign stall  = held_valid & (rs_hit | rt_hit);

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
    input  logic [mips_decode_pkg::DATA_W-1:0] held_pc,
    input  logic [mips_decode_pkg::INST_W-1:0] held_inst,
    input  logic [mips_decode_pkg::DATA_W-1:0] rs_value,
    input  logic [mips_decode_pkg::DATA_W-1:0] rt_value,
    input  logic                               issue,
    output logic                               jbr_taken,
    output logic [mips_decode_pkg::DATA_W-1:0] jbr_target
);

    logic [5:0]  op, funct;
    logic [4:0]  rt, rd, sa;
    logic [15:0] offset;
    logic [25:0] target;

    assign op     = held_inst[31:26];
    assign rt     = held_inst[20:16];
    assign rd     = held_inst[15:11];
    assign sa     = held_inst[10:6];
    assign funct  = held_inst[5:0];
    assign offset = held_inst[15:0];
    assign target = held_inst[25:0];

    //************************************************************
    // jump and branch identification
    //************************************************************
    logic is_j, is_jr, is_regimm, rt_zero;

    assign rt_zero   = (rt == mips_decode_pkg::REG_ZERO);
    assign is_regimm = (op == mips_decode_pkg::OP_REGIMM);
    assign is_j      = op inside {mips_decode_pkg::OP_J, mips_decode_pkg::OP_JAL};
    assign is_jr     = (op == mips_decode_pkg::OP_SPECIAL) & rt_zero & (sa == 5'd0)
                     & (((funct == mips_decode_pkg::FN_JR) & (rd == mips_decode_pkg::REG_ZERO))
                     | ((funct == mips_decode_pkg::FN_JALR) & (rd == mips_decode_pkg::LINK_REG)));

    logic rs_eq_rt, rs_ez, rs_ltz;

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == '0);
    assign rs_ltz   = rs_value[mips_decode_pkg::DATA_W-1];   // sign bit

    logic j_taken, br_taken;

    assign j_taken  = is_j | is_jr;
    assign br_taken = ((op == mips_decode_pkg::OP_BEQ) & rs_eq_rt)
                    | ((op == mips_decode_pkg::OP_BNE) & ~rs_eq_rt)
                    | ((op == mips_decode_pkg::OP_BGTZ) & rt_zero & ~rs_ltz & ~rs_ez)
                    | ((op == mips_decode_pkg::OP_BLEZ) & rt_zero & (rs_ltz | rs_ez))
                    | (is_regimm & (rt inside {mips_decode_pkg::RI_BGEZ,
                                               mips_decode_pkg::RI_BGEZAL}) & ~rs_ltz)
                    | (is_regimm & (rt inside {mips_decode_pkg::RI_BLTZ,
                                               mips_decode_pkg::RI_BLTZAL}) & rs_ltz);

    //************************************************************
    // targets, relative to the delay slot
    //************************************************************
    logic [mips_decode_pkg::DATA_W-1:0] bd_pc, j_target, br_target;

    assign bd_pc     = held_pc + mips_decode_pkg::DELAY_SLOT_OFFSET;
    assign j_target  = is_jr ? rs_value : {bd_pc[31:28], target, 2'b00};
    assign br_target = bd_pc + {{(mips_decode_pkg::DATA_W-18){offset[15]}}, offset, 2'b00};

    assign jbr_taken  = (j_taken | br_taken) & issue;   // redirect only once, on issue
    assign jbr_target = j_taken ? j_target : br_target;

endmodule

/* rtl/id_exe_reg.sv */
`timescale 1ns/1ns

module id_exe_reg (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   issue,
    input  logic [mips_decode_pkg::DATA_W-1:0]     held_pc,
    decode_bus_if.exe_reg                          bus,
    input  logic                                   exe_ready,
    output logic                                   can_accept,
    output logic                                   exe_valid,
    output mips_decode_pkg::alu_op_e               exe_alu_op,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_operand1,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_operand2,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_pc,
    output logic                                   exe_rf_wen,
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_rf_wdest
);

    // free, or the bundle leaves for execute this cycle
    assign can_accept = ~exe_valid | exe_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (can_accept) begin
            exe_valid <= issue;                 // clears unless replaced
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            exe_alu_op   <= bus.alu_op;
            exe_operand1 <= bus.operand1;
            exe_operand2 <= bus.operand2;
            exe_rf_wen   <= bus.rf_wen;
            exe_rf_wdest <= bus.rf_wdest;
            exe_pc       <= held_pc;
        end
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                                   clk,
    input  logic                                   reset,
    // fetch side
    input  logic                                   fetch_valid,
    input  logic [mips_decode_pkg::DATA_W-1:0]     fetch_pc,
    input  logic [mips_decode_pkg::INST_W-1:0]     fetch_inst,
    output logic                                   fetch_ready,
    // register file, read in the same cycle
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [mips_decode_pkg::DATA_W-1:0]     rs_value,
    input  logic [mips_decode_pkg::DATA_W-1:0]     rt_value,
    // pending destinations of later stages
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_wdest,
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] mem_wdest,
    input  logic [mips_decode_pkg::REG_ADDR_W-1:0] wb_wdest,
    // execute side
    output logic                                   exe_valid,
    input  logic                                   exe_ready,
    output mips_decode_pkg::alu_op_e               exe_alu_op,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_operand1,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_operand2,
    output logic                                   exe_rf_wen,
    output logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_rf_wdest,
    output logic [mips_decode_pkg::DATA_W-1:0]     exe_pc,
    // redirect to fetch
    output logic                                   jbr_taken,
    output logic [mips_decode_pkg::DATA_W-1:0]     jbr_target
);

    logic                               held_valid;
    logic [mips_decode_pkg::DATA_W-1:0] held_pc;
    logic [mips_decode_pkg::INST_W-1:0] held_inst;
    logic                               stall;
    logic                               can_accept;
    logic                               issue;

    decode_bus_if dec_bus ();

    id_inst_reg u_id_inst_reg (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .stall       (stall),
        .can_accept  (can_accept),
        .fetch_ready (fetch_ready),
        .held_valid  (held_valid),
        .held_pc     (held_pc),
        .held_inst   (held_inst),
        .issue       (issue)
    );

    inst_decoder u_inst_decoder (
        .held_valid (held_valid),
        .held_pc    (held_pc),
        .held_inst  (held_inst),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .exe_wdest  (exe_wdest),
        .mem_wdest  (mem_wdest),
        .wb_wdest   (wb_wdest),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .stall      (stall),
        .dec        (dec_bus.dec)
    );

    branch_unit u_branch_unit (
        .held_pc    (held_pc),
        .held_inst  (held_inst),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .issue      (issue),
        .jbr_taken  (jbr_taken),
        .jbr_target (jbr_target)
    );

    id_exe_reg u_id_exe_reg (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .held_pc      (held_pc),
        .bus          (dec_bus.exe_reg),
        .exe_ready    (exe_ready),
        .can_accept   (can_accept),
        .exe_valid    (exe_valid),
        .exe_alu_op   (exe_alu_op),
        .exe_operand1 (exe_operand1),
        .exe_operand2 (exe_operand2),
        .exe_pc       (exe_pc),
        .exe_rf_wen   (exe_rf_wen),
        .exe_rf_wdest (exe_rf_wdest)
    );

endmodule

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ns

module decode_stage_tb;

    localparam int          CLK_PERIOD     = 40;
    localparam int          DRIVE_DELAY    = 2;   // inputs move this long after the edge
    localparam int          RESET_CYCLES   = 16;
    localparam int          CYCLES_PER_ROW = 64;  // watchdog budget per row
    localparam int          MAX_ROWS       = 64;
    localparam logic [31:0] RAND_SEED      = 32'h3c0b91ec;

    logic                                   clk;
    logic                                   reset;
    logic                                   fetch_valid;
    logic [mips_decode_pkg::DATA_W-1:0]     fetch_pc;
    logic [mips_decode_pkg::INST_W-1:0]     fetch_inst;
    logic                                   fetch_ready;
    logic [mips_decode_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr;
    logic [mips_decode_pkg::DATA_W-1:0]     rs_value, rt_value;
    logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_wdest, mem_wdest, wb_wdest;
    logic                                   exe_valid;
    logic                                   exe_ready;
    mips_decode_pkg::alu_op_e               exe_alu_op;
    logic [mips_decode_pkg::DATA_W-1:0]     exe_operand1, exe_operand2, exe_pc;
    logic                                   exe_rf_wen;
    logic [mips_decode_pkg::REG_ADDR_W-1:0] exe_rf_wdest;
    logic                                   jbr_taken;
    logic [mips_decode_pkg::DATA_W-1:0]     jbr_target;

    //************************************************************
    // stimulus rows, one entry per instruction
    //************************************************************
    logic [31:0] row_pc        [MAX_ROWS];
    logic [31:0] row_inst      [MAX_ROWS];
    logic [31:0] row_rs        [MAX_ROWS];
    logic [31:0] row_rt        [MAX_ROWS];
    logic [31:0] row_hz_dest   [MAX_ROWS];  // pending destination of a later stage
    logic [31:0] row_hz_cycles [MAX_ROWS];
    logic [31:0] row_alu_op    [MAX_ROWS];
    logic [31:0] row_op1       [MAX_ROWS];
    logic [31:0] row_op2       [MAX_ROWS];
    logic [31:0] row_wen       [MAX_ROWS];
    logic [31:0] row_wdest     [MAX_ROWS];
    logic [31:0] row_taken     [MAX_ROWS];
    logic [31:0] row_target    [MAX_ROWS];

    int   row_count        = 0;
    int   rows_done        = 0;     // rows taken by execute
    int   checks           = 0;
    int   errors           = 0;
    logic rows_loaded      = 1'b0;
    int   expect_q [$];             // issued rows, oldest first
    logic redirect_pending = 1'b0;
    int   redirect_idx     = 0;

    decode_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    task automatic load_rows();
        int    fd;
        int    fields;
        string line;
        fd = $fopen("sim/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open sim/decode_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && row_count < MAX_ROWS) begin
                line   = "";
                fields = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin  // skip column notes
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     row_pc[row_count], row_inst[row_count],
                                     row_rs[row_count], row_rt[row_count],
                                     row_hz_dest[row_count], row_hz_cycles[row_count],
                                     row_alu_op[row_count], row_op1[row_count],
                                     row_op2[row_count], row_wen[row_count],
                                     row_wdest[row_count], row_taken[row_count],
                                     row_target[row_count]);
                    if (fields == 13) begin
                        row_count++;
                    end else begin
                        $display("error: stimulus row %0d is malformed", row_count);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        rows_loaded = 1'b1;
    endtask

    // stage 0 is exe, 1 is mem, 2 is wb
    task automatic drive_hazard(input int stage, input logic [4:0] dest);
        exe_wdest = (stage == 0) ? dest : mips_decode_pkg::REG_ZERO;
        mem_wdest = (stage == 1) ? dest : mips_decode_pkg::REG_ZERO;
        wb_wdest  = (stage == 2) ? dest : mips_decode_pkg::REG_ZERO;
    endtask

    task automatic compare_bundle(input int idx);
        check_value("exe_alu_op", exe_alu_op, row_alu_op[idx]);
        check_value("exe_operand1", exe_operand1, row_op1[idx]);
        check_value("exe_operand2", exe_operand2, row_op2[idx]);
        check_value("exe_rf_wen", exe_rf_wen, row_wen[idx]);
        check_value("exe_rf_wdest", exe_rf_wdest, row_wdest[idx]);
        check_value("exe_pc", exe_pc, row_pc[idx]);
    endtask

    task automatic send_row(input int idx);
        int         k;
        logic [4:0] hz_dest;
        hz_dest     = row_hz_dest[idx][4:0];
        fetch_valid = 1'b1;
        fetch_pc    = row_pc[idx];
        fetch_inst  = row_inst[idx];
        rs_value    = row_rs[idx];
        rt_value    = row_rt[idx];
        drive_hazard(idx % 3, hz_dest);
        @(negedge clk);
        while (!fetch_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                         // accept edge
        expect_q.push_back(idx);
        redirect_idx     = idx;
        redirect_pending = 1'b1;
        #DRIVE_DELAY;
        fetch_valid = 1'b0;
        if (row_hz_cycles[idx] > 0) begin
            for (k = 0; k < row_hz_cycles[idx]; k++) begin
                @(negedge clk);
                if (hz_dest != mips_decode_pkg::REG_ZERO) begin
                    check_value("exe_valid", exe_valid, 1'b0);  // held by the hazard
                end else if (k == 1) begin
                    check_value("exe_valid", exe_valid, 1'b1);  // r0 never waits
                end
                @(posedge clk);
            end
            #DRIVE_DELAY;
        end
        drive_hazard(0, mips_decode_pkg::REG_ZERO);
        wait (rows_done == idx + 1);            // register values stay until execute takes it
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    //************************************************************
    // fetch side and register file
    //************************************************************
    initial begin
        int idx;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst  = '0;
        rs_value    = '0;
        rt_value    = '0;
        drive_hazard(0, mips_decode_pkg::REG_ZERO);
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (idx = 0; idx < row_count; idx++) begin
            send_row(idx);
        end
        repeat (4) @(posedge clk);
        report_counts();
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    //************************************************************
    // execute side with random back-pressure
    //************************************************************
    initial begin
        int          idx;
        logic [31:0] first_word;
        exe_ready  = 1'b0;
        first_word = $urandom(RAND_SEED);
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            if (exe_valid) begin
                if (expect_q.size() == 0) begin
                    $display("error: exe_valid high with no row pending at %0t", $time);
                    errors++;
                end else begin
                    compare_bundle(expect_q[0]);    // also while it waits
                    if (exe_ready) begin
                        idx = expect_q.pop_front();
                        rows_done++;
                    end
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
            exe_ready = ($urandom % 4) != 0;        // low about one cycle in four
        end
    end

    // redirect shows only in the issue cycle, when fetch_ready rises
    initial begin
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            if (redirect_pending && fetch_ready) begin
                check_value("rs_addr", rs_addr, row_inst[redirect_idx][25:21]);
                check_value("rt_addr", rt_addr, row_inst[redirect_idx][20:16]);
                check_value("jbr_taken", jbr_taken, row_taken[redirect_idx]);
                if (row_taken[redirect_idx][0]) begin
                    check_value("jbr_target", jbr_target, row_target[redirect_idx]);
                end
                redirect_pending = 1'b0;
            end else begin
                check_value("jbr_taken", jbr_taken, 1'b0);
            end
        end
    end

    initial begin
        wait (rows_loaded);
        repeat (row_count * CYCLES_PER_ROW + RESET_CYCLES) @(posedge clk);
        $display("timeout: the rows did not all reach execute in time");
        report_counts();
        $display("test failed");
        $finish;
    end

endmodule

/* sim/decode_stimulus.txt */
# pc inst rs_value rt_value hz_dest hz_cycles alu_op operand1 operand2 rf_wen rf_wdest taken target
# all hex; hz_dest goes to exe, mem, wb in turn by row; alu_op in alu_op_e order
00400000 00221821 00000005 00000007 00 00 0 00000005 00000007 1 03 0 00000000
00400004 00a62023 00000010 00000003 00 00 1 00000010 00000003 1 04 0 00000000
00400008 016c5027 0f0f0f0f 00ff00ff 00 00 5 0f0f0f0f 00ff00ff 1 0a 0 00000000
0040000c 00031100 00000000 12345678 00 00 8 00000004 12345678 1 02 0 00000000
00400010 00062fc3 00000000 80000000 00 00 a 0000001f 80000000 1 05 0 00000000
00400014 01494006 00000003 f0000000 00 00 9 00000003 f0000000 1 08 0 00000000
00400018 2422fffc 00000100 00000000 00 00 0 00000100 fffffffc 1 02 0 00000000
0040001c 2cc57fff 00000001 00000000 00 00 3 00000001 00007fff 1 05 0 00000000
00400020 35498001 0000f0f0 00000000 00 00 6 0000f0f0 00008001 1 09 0 00000000
00400024 3c0d8765 00000000 00000000 00 00 b 00000000 00008765 1 0d 0 00000000
00400100 10220010 00000005 00000005 00 00 0 00000005 00000005 0 00 1 00400144
00400200 1464fffc 00000001 00000001 00 00 0 00000001 00000001 0 00 0 004001f4
00400400 1ca00008 00000001 00000000 00 00 0 00000001 00000000 0 00 1 00400424
00400800 05100002 80000000 00000000 00 00 0 00400800 00000008 1 1f 1 0040080c
00400900 0531ffff 80000000 00000000 00 00 0 00400900 00000008 1 1f 0 00400900
1ffffffc 08100040 00000000 00000000 00 00 0 00000000 00000000 0 00 1 20400100
00401000 0c000100 00000000 00000000 00 00 0 00401000 00000008 1 1f 1 00000400
00401200 0080f809 00402000 00000000 00 00 0 00401200 00000008 1 1f 1 00402000
00402000 00221821 00000011 00000022 02 04 0 00000011 00000022 1 03 0 00000000
00402004 24a20001 00000009 00000000 05 03 0 00000009 00000001 1 02 0 00000000
00402200 00e00008 00403000 00000000 07 03 0 00403000 00000000 0 00 1 00403000
00402300 00021821 00000000 00000022 00 03 0 00000000 00000022 1 03 0 00000000
00402400 fc000000 00000000 00000000 00 00 0 00000000 00000000 0 00 0 00000000

/* list.f */
rtl/mips_decode_pkg.sv
rtl/decode_bus_if.sv
rtl/id_inst_reg.sv
rtl/inst_decoder.sv
rtl/branch_unit.sv
rtl/id_exe_reg.sv
rtl/decode_stage.sv
sim/decode_stage_tb.sv

/* Bender.yml */
package:
  name: mips_decode_stage

sources:
  # package and interface before the modules that use them
  - rtl/mips_decode_pkg.sv
  - rtl/decode_bus_if.sv
  - rtl/id_inst_reg.sv
  - rtl/inst_decoder.sv
  - rtl/branch_unit.sv
  - rtl/id_exe_reg.sv
  - rtl/decode_stage.sv

  - target: simulation
    files:
      - sim/decode_stage_tb.sv
